//--- Makefile
TOP       ?= processorTb
FILELIST  ?= all.f
BUILD     ?= build
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: compile
	-./$(SIM) > $(LOG) 2>&1
	@if grep -q "Something failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif grep -q "Everything OK" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: no result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- all.f
logic/cpuPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/hazardUnit.sv
logic/memArbiter.sv
logic/processor.sv
dv/processor_sva.sv
dv/processorTb.sv

//--- dv/processorTb.sv
`timescale 1ns/1ns

module processorTb;

    import cpuPkg::*;

    localparam int          ADDR_WIDTH   = 16;
    localparam int          MEM_WORDS    = 1 << (ADDR_WIDTH - 2);
    localparam int          RESET_CYCLES = 5;
    localparam int          WAIT_CYCLES  = 200;
    localparam logic [15:0] DONE_MARK    = 16'h0d0e;

    // MIPS primary opcodes and R-type function codes.
    localparam logic [5:0] CODE_J     = 6'h02;
    localparam logic [5:0] CODE_BEQ   = 6'h04;
    localparam logic [5:0] CODE_BNE   = 6'h05;
    localparam logic [5:0] CODE_ADDI  = 6'h08;
    localparam logic [5:0] CODE_LW    = 6'h23;
    localparam logic [5:0] CODE_SW    = 6'h2b;
    localparam logic [5:0] FUNCT_MOVZ = 6'h0a;
    localparam logic [5:0] FUNCT_MOVN = 6'h0b;
    localparam logic [5:0] FUNCT_ADD  = 6'h20;
    localparam logic [5:0] FUNCT_SUB  = 6'h22;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_SLT  = 6'h2a;

    logic        Clock = 1'b0;
    logic        nReset;
    memReq_t     memBus;
    logic [31:0] memRdata;
    logic [4:0]  regAddr;
    logic [31:0] regData;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] prog [$];
    logic [31:0] logAddr [$];
    logic [31:0] logData [$];
    int          loadSeq   = 0;
    int          loadedSeq = 0;

    processor #(.ADDR_WIDTH(ADDR_WIDTH)) processor_i (
        .Clock   (Clock),
        .nReset  (nReset),
        .memBus  (memBus),
        .memRdata(memRdata),
        .regAddr (regAddr),
        .regData (regData)
    );

    always #10 Clock = ~Clock;

    // ==============================
    // memory model
    // ==============================

    assign memRdata = mem[memBus.addr[ADDR_WIDTH-1:2]];

    always @(posedge Clock) begin
        if (loadSeq != loadedSeq) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= (i < prog.size()) ? prog[i] : 32'd0; // zero word is a nop.
            end
            logAddr.delete();
            logData.delete();
            loadedSeq <= loadSeq;
        end else if (memBus.write) begin
            mem[memBus.addr[ADDR_WIDTH-1:2]] <= memBus.wrData;
            logAddr.push_back(memBus.addr);
            logData.push_back(memBus.wrData);
        end
    end

    // bus rules, sampled mid-cycle.
    always @(negedge Clock) begin
        checkValue("bus read with write", 32'd0, 32'(memBus.read & memBus.write));
        if (!nReset) begin
            checkValue("bus write in reset", 32'd0, 32'(memBus.write));
            checkValue("bus read in reset", 32'd0, 32'(memBus.read));
        end
        if (memBus.write) begin
            checkValue("write address alignment", 32'd0, 32'(memBus.addr[1:0]));
        end
    end

    // ==============================
    // helpers
    // ==============================

    task automatic failRun();
        $display("Something failed");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s: expected %h, got %h", $time, what, expected, actual);
            failRun();
        end
    endtask

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic asmR(input logic [5:0] funct, input int rd, input int rs, input int rt);
        prog.push_back({6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct});
    endtask

    task automatic asmI(input logic [5:0] op, input int rt, input int rs,
                        input logic [15:0] imm);
        prog.push_back({op, 5'(rs), 5'(rt), imm});
    endtask

    task automatic asmJ(input int index);
        prog.push_back({CODE_J, 26'(index)});
    endtask

    // reset the cpu and swap in the assembled image.
    task automatic loadProgram();
        @(posedge Clock);
        nReset <= 1'b0;
        @(negedge Clock);
        loadSeq = loadSeq + 1;
        repeat (RESET_CYCLES) @(posedge Clock);
        prog.delete();
        nReset <= 1'b1;
    endtask

    task automatic readReg(input int r, output logic [31:0] v);
        @(posedge Clock);
        regAddr <= 5'(r);
        @(negedge Clock);
        v = regData;
    endtask

    task automatic checkReg(input int r, input logic [31:0] expected);
        logic [31:0] v;
        readReg(r, v);
        checkValue($sformatf("register r%0d", r), expected, v);
    endtask

    task automatic waitReg(input int r, input logic [31:0] value);
        int          cycles;
        logic [31:0] seen;
        cycles = 0;
        readReg(r, seen);
        while (seen !== value) begin
            if (cycles >= WAIT_CYCLES) begin
                $display("timeout waiting for register r%0d to become %h", r, value);
                failRun();
            end else begin
                cycles++;
                @(negedge Clock);
                seen = regData;
            end
        end
    endtask

    // movz writes on a zero rt, movn on a nonzero rt.
    function automatic logic [31:0] moveResult(input bit onNonzero, input logic [31:0] rtVal,
                                               input logic [31:0] src, input logic [31:0] old);
        return ((rtVal != 32'd0) == onNonzero) ? src : old;
    endfunction

    task automatic checkMarkers(input int first, input bit skipped);
        checkReg(first, skipped ? 32'd0 : 32'(first));
        checkReg(first + 1, skipped ? 32'd0 : 32'(first + 1));
    endtask

    // ==============================
    // directed tests
    // ==============================

    task automatic testReset();
        asmI(CODE_ADDI, 31, 0, DONE_MARK);
        loadProgram();
        @(negedge Clock);
        checkValue("first fetch address", 32'd0, memBus.addr);
        checkValue("first fetch read", 32'd1, 32'(memBus.read));
        checkValue("first fetch write", 32'd0, 32'(memBus.write));
        waitReg(31, sext16(DONE_MARK));
    endtask

    task automatic testAlu();
        logic [15:0] a;
        logic [15:0] b;
        logic [31:0] x [1:7];
        a = 16'($urandom);
        b = 16'($urandom);
        x[1] = sext16(a);
        x[2] = sext16(b);
        x[3] = x[1] + x[2];
        x[4] = x[3] - x[1];
        x[5] = x[4] & x[2];
        x[6] = x[5] | x[3];
        x[7] = ($signed(x[4]) < $signed(x[6])) ? 32'd1 : 32'd0;
        asmI(CODE_ADDI, 1, 0, a);
        asmI(CODE_ADDI, 2, 0, b);
        asmR(FUNCT_ADD, 3, 1, 2);
        asmR(FUNCT_SUB, 4, 3, 1);
        asmR(FUNCT_AND, 5, 4, 2);
        asmR(FUNCT_OR, 6, 5, 3);
        asmR(FUNCT_SLT, 7, 4, 6);
        asmI(CODE_ADDI, 31, 0, DONE_MARK);
        loadProgram();
        waitReg(31, sext16(DONE_MARK));
        for (int r = 1; r <= 7; r++) begin
            checkReg(r, x[r]);
        end
    endtask

    task automatic testLoadStore();
        logic [15:0] v;
        logic [15:0] k;
        v = 16'($urandom);
        k = 16'($urandom);
        asmI(CODE_ADDI, 1, 0, 16'h4000);
        asmI(CODE_ADDI, 2, 0, v);
        asmI(CODE_ADDI, 5, 0, k);
        asmI(CODE_SW, 2, 1, 16'h0004);
        asmI(CODE_LW, 3, 1, 16'h0004);
        asmR(FUNCT_ADD, 4, 3, 5); // load-use.
        asmI(CODE_ADDI, 31, 0, DONE_MARK);
        loadProgram();
        waitReg(31, sext16(DONE_MARK));
        checkValue("store count", 32'd1, 32'(logAddr.size()));
        checkValue("store address", 32'h0000_4004, logAddr[0]);
        checkValue("store data", sext16(v), logData[0]);
        checkReg(3, sext16(v));
        checkReg(4, sext16(v) + sext16(k));
    endtask

    task automatic testBranches();
        asmI(CODE_ADDI, 1, 0, 16'd5);
        asmI(CODE_ADDI, 2, 0, 16'd5);
        asmI(CODE_ADDI, 3, 0, 16'd7);
        asmI(CODE_BEQ, 2, 1, 16'd2);   // taken.
        asmI(CODE_ADDI, 10, 0, 16'd10);
        asmI(CODE_ADDI, 11, 0, 16'd11);
        asmI(CODE_BNE, 2, 1, 16'd2);   // not taken.
        asmI(CODE_ADDI, 12, 0, 16'd12);
        asmI(CODE_ADDI, 13, 0, 16'd13);
        asmI(CODE_BNE, 3, 1, 16'd2);   // taken.
        asmI(CODE_ADDI, 14, 0, 16'd14);
        asmI(CODE_ADDI, 15, 0, 16'd15);
        asmI(CODE_BEQ, 3, 1, 16'd2);   // not taken.
        asmI(CODE_ADDI, 16, 0, 16'd16);
        asmI(CODE_ADDI, 17, 0, 16'd17);
        asmJ(18);
        asmI(CODE_ADDI, 18, 0, 16'd18);
        asmI(CODE_ADDI, 19, 0, 16'd19);
        asmI(CODE_ADDI, 31, 0, DONE_MARK); // word 18.
        loadProgram();
        waitReg(31, sext16(DONE_MARK));
        checkMarkers(10, 1'b1);
        checkMarkers(12, 1'b0);
        checkMarkers(14, 1'b1);
        checkMarkers(16, 1'b0);
        checkMarkers(18, 1'b1);
    endtask

    task automatic testCondMove();
        logic [31:0] src;
        logic [31:0] old;
        src = 32'h0000_0123;
        old = 32'h0000_0055;
        asmI(CODE_ADDI, 1, 0, src[15:0]);
        asmI(CODE_ADDI, 3, 0, 16'd9);
        for (int r = 20; r <= 23; r++) begin
            asmI(CODE_ADDI, r, 0, old[15:0]);
        end
        asmR(FUNCT_MOVZ, 20, 1, 0);
        asmR(FUNCT_MOVZ, 21, 1, 3);
        asmR(FUNCT_MOVN, 22, 1, 0);
        asmR(FUNCT_MOVN, 23, 1, 3);
        asmI(CODE_ADDI, 31, 0, DONE_MARK);
        loadProgram();
        waitReg(31, sext16(DONE_MARK));
        checkReg(20, moveResult(1'b0, 32'd0, src, old));
        checkReg(21, moveResult(1'b0, 32'd9, src, old));
        checkReg(22, moveResult(1'b1, 32'd0, src, old));
        checkReg(23, moveResult(1'b1, 32'd9, src, old));
    endtask

    task automatic testBusOrder();
        logic [15:0] v;
        logic [31:0] x [2:6];
        logic [31:0] expAddr [$];
        logic [31:0] expData [$];
        v = 16'($urandom);
        x[2] = sext16(v);
        x[3] = x[2] + x[2];
        x[4] = x[3] - x[2];
        x[5] = x[4] | x[3];
        x[6] = x[5] + 32'd1;
        asmI(CODE_ADDI, 1, 0, 16'h4100);
        asmI(CODE_ADDI, 2, 0, v);
        asmI(CODE_SW, 2, 1, 16'd0);
        expAddr.push_back(32'h4100);
        expData.push_back(x[2]);
        asmR(FUNCT_ADD, 3, 2, 2);
        asmI(CODE_SW, 3, 1, 16'd4);
        expAddr.push_back(32'h4104);
        expData.push_back(x[3]);
        asmR(FUNCT_SUB, 4, 3, 2);
        asmR(FUNCT_OR, 5, 4, 3);
        asmI(CODE_SW, 5, 1, 16'd8);    // back to back stores.
        expAddr.push_back(32'h4108);
        expData.push_back(x[5]);
        asmI(CODE_SW, 4, 1, 16'd12);
        expAddr.push_back(32'h410c);
        expData.push_back(x[4]);
        asmI(CODE_ADDI, 6, 5, 16'd1);
        asmI(CODE_SW, 6, 1, 16'd0);
        expAddr.push_back(32'h4100);
        expData.push_back(x[6]);
        asmI(CODE_ADDI, 31, 0, DONE_MARK);
        loadProgram();
        waitReg(31, sext16(DONE_MARK));
        checkValue("store count", 32'(expAddr.size()), 32'(logAddr.size()));
        for (int i = 0; i < expAddr.size(); i++) begin
            checkValue($sformatf("store %0d address", i), expAddr[i], logAddr[i]);
            checkValue($sformatf("store %0d data", i), expData[i], logData[i]);
        end
    endtask

    initial begin
        void'($urandom(1));
        nReset  <= 1'b0;
        regAddr <= 5'd0;
        testReset();
        testAlu();
        testLoadStore();
        testBranches();
        testCondMove();
        testBusOrder();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- dv/processor_sva.sv
`timescale 1ns/1ns

module processor_sva (
    input logic            Clock,
    input logic            nReset,
    input cpuPkg::memReq_t memBus
);

    readWriteExclusive: assert property (
        @(posedge Clock) !(memBus.read && memBus.write)
    ) else $error("memory bus read and write high in the same cycle");

    // async reset must hold stores off.
    noWriteInReset: assert property (
        @(posedge Clock) !nReset |-> !memBus.write
    ) else $error("memory bus write during reset");

    alignedWrite: assert property (
        @(posedge Clock) disable iff (!nReset)
        memBus.write |-> (memBus.addr[1:0] == 2'b00)
    ) else $error("memory bus write to an unaligned address");

endmodule

bind processor processor_sva sva_i (
    .Clock (Clock),
    .nReset(nReset),
    .memBus(memBus)
);

//--- logic/cpuPkg.sv
package cpuPkg;

    // ==============================
    // instruction encodings
    // ==============================

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_MOVZ = 6'h0a,
        FN_MOVN = 6'h0b,
        FN_ADD  = 6'h20,
        FN_SUB  = 6'h22,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_PASSA
    } aluOp_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } rType_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iType_t;

    // one fetched word, two views.
    typedef union packed {
        rType_t r;
        iType_t i;
    } instr_t;

    // ==============================
    // pipeline and bus types
    // ==============================

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   aluSrc;
        logic   branch;
        logic   branchNe;
        logic   jump;
        logic   condMove;
        logic   condMoveNz;
        aluOp_t aluOp;
    } ctrl_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwdSel_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wrData;
        logic        read;
        logic        write;
    } memReq_t;

endpackage

//--- logic/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
    input  logic           Clock,
    input  logic           nReset,
    input  cpuPkg::instr_t instr,
    input  logic           wrEn,
    input  logic [4:0]     wrAddr,
    input  logic [31:0]    wrData,
    input  logic [4:0]     regAddr,
    output logic [31:0]    regData,
    output cpuPkg::ctrl_t  ctrl,
    output logic [31:0]    rsData,
    output logic [31:0]    rtData,
    output logic [31:0]    imm,
    output logic [4:0]     rs,
    output logic [4:0]     rt,
    output logic [4:0]     rd
);

    import cpuPkg::*;

    logic [31:0] regs [32];
    logic        isRType;

    // ==============================
    // register file
    // ==============================

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rs = instr.i.rs;
    assign rt = instr.i.rt;

    // same-cycle writeback bypasses the array.
    assign rsData = (rs == 5'd0) ? '0 : (wrEn && wrAddr == rs) ? wrData : regs[rs];
    assign rtData = (rt == 5'd0) ? '0 : (wrEn && wrAddr == rt) ? wrData : regs[rt];

    assign regData = regs[regAddr]; // debug view.

    // ==============================
    // control decode
    // ==============================

    assign isRType = (instr.r.opcode == OP_RTYPE);
    assign rd      = isRType ? instr.r.rd : instr.i.rt;

    assign imm = (instr.i.opcode == OP_J)
               ? {6'b0, instr.r.rs, instr.r.rt, instr.r.rd, instr.r.shamt, instr.r.funct}
               : {{16{instr.i.imm[15]}}, instr.i.imm};

    always_comb begin
        ctrl = '0;
        case (instr.i.opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                case (instr.r.funct)
                    FN_ADD:  ctrl.aluOp = ALU_ADD;
                    FN_SUB:  ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    FN_MOVZ: begin
                        ctrl.aluOp    = ALU_PASSA;
                        ctrl.condMove = 1'b1;
                    end
                    FN_MOVN: begin
                        ctrl.aluOp      = ALU_PASSA;
                        ctrl.condMove   = 1'b1;
                        ctrl.condMoveNz = 1'b1;
                    end
                    default: ctrl = '0; // unknown funct is a nop.
                endcase
            end
            OP_ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            OP_LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            OP_BEQ:  ctrl.branch = 1'b1;
            OP_BNE: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = 1'b1;
            end
            OP_J:    ctrl.jump = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ns

module executeStage (
    input  cpuPkg::ctrl_t ctrl,
    input  logic [31:0]   pc,
    input  logic [31:0]   opA,
    input  logic [31:0]   opB,
    input  logic [31:0]   imm,
    output logic [31:0]   aluResult,
    output logic          regWriteOut,
    output logic          branchTaken,
    output logic [31:0]   branchTarget
);

    import cpuPkg::*;

    logic [31:0] opBSel;
    logic [31:0] pcPlus4;
    logic        operandsEqual;

    assign opBSel = ctrl.aluSrc ? imm : opB;

    // ==============================
    // ALU
    // ==============================

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD:   aluResult = opA + opBSel;
            ALU_SUB:   aluResult = opA - opBSel;
            ALU_AND:   aluResult = opA & opBSel;
            ALU_OR:    aluResult = opA | opBSel;
            ALU_SLT:   aluResult = {31'b0, $signed(opA) < $signed(opBSel)};
            ALU_PASSA: aluResult = opA; // movz and movn copy rs.
            default:   aluResult = '0;
        endcase
    end

    // conditional moves test rt.
    always_comb begin
        if (ctrl.condMove) begin
            regWriteOut = ctrl.regWrite && (ctrl.condMoveNz ? (opB != '0) : (opB == '0));
        end else begin
            regWriteOut = ctrl.regWrite;
        end
    end

    // ==============================
    // branch and jump
    // ==============================

    assign operandsEqual = (opA == opB);
    assign branchTaken   = ctrl.jump || (ctrl.branch && (operandsEqual ^ ctrl.branchNe));
    assign pcPlus4       = pc + 32'd4;

    always_comb begin
        if (ctrl.jump) begin
            branchTarget = {pcPlus4[31:28], imm[25:0], 2'b00}; // index in imm.
        end else begin
            branchTarget = pcPlus4 + {imm[29:0], 2'b00};
        end
    end

endmodule

//--- logic/fetchStage.sv
`timescale 1ns/1ns

module fetchStage #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic           Clock,
    input  logic           nReset,
    input  logic           hold,
    input  logic           fetchGrant,
    input  logic           branchTaken,
    input  logic [31:0]    branchTarget,
    input  logic [31:0]    fetchData,
    output logic [31:0]    pc,
    output cpuPkg::instr_t instr,
    output logic           instrValid
);

    import cpuPkg::*;

    logic [ADDR_WIDTH-1:0] pcReg;
    logic [ADDR_WIDTH-1:0] pcNext;

    always_comb begin
        pcNext = pcReg;
        if (branchTaken) begin
            pcNext = branchTarget[ADDR_WIDTH-1:0]; // redirect wins over hold.
        end else if (fetchGrant && !hold) begin
            pcNext = pcReg + ADDR_WIDTH'(4);
        end
    end

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            pcReg <= '0;
        end else begin
            pcReg <= pcNext;
        end
    end

    assign pc    = 32'(pcReg);
    assign instr = instr_t'(fetchData);

    // denied or redirected fetch becomes a bubble.
    assign instrValid = fetchGrant && !branchTaken;

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
    input  logic            exRegWrite,
    input  logic            exMemRead,
    input  logic [4:0]      exRd,
    input  logic            memRegWrite,
    input  logic [4:0]      memRd,
    input  logic            wbRegWrite,
    input  logic [4:0]      wbRd,
    input  logic [4:0]      exRs,
    input  logic [4:0]      exRt,
    input  logic [4:0]      decRs,
    input  logic [4:0]      decRt,
    input  logic            branchTaken,
    output cpuPkg::fwdSel_t fwdA,
    output cpuPkg::fwdSel_t fwdB,
    output logic            stall,
    output logic            flush
);

    import cpuPkg::*;

    logic loadInEx;

    // youngest producer first.
    function automatic fwdSel_t pickSource(
        input logic [4:0] src,
        input logic       mWrite,
        input logic [4:0] mRd,
        input logic       wWrite,
        input logic [4:0] wRd
    );
        if (src == 5'd0) begin
            return FWD_REG;
        end
        if (mWrite && mRd == src) begin
            return FWD_MEM;
        end
        if (wWrite && wRd == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwdA = pickSource(exRs, memRegWrite, memRd, wbRegWrite, wbRd);
    assign fwdB = pickSource(exRt, memRegWrite, memRd, wbRegWrite, wbRd);

    // load data is only ready in writeback for the next consumer.
    assign loadInEx = exMemRead && exRegWrite && (exRd != 5'd0);
    assign stall    = loadInEx && (exRd == decRs || exRd == decRt);
    assign flush    = branchTaken;

endmodule

//--- logic/memArbiter.sv
`timescale 1ns/1ns

module memArbiter #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic [31:0]     pc,
    input  logic [31:0]     dataAddr,
    input  logic [31:0]     dataWr,
    input  logic            dataRead,
    input  logic            dataWrite,
    output cpuPkg::memReq_t memBus,
    output logic            fetchGrant
);

    logic        dataAccess;
    logic [31:0] rawAddr;

    assign dataAccess = dataRead || dataWrite;
    assign fetchGrant = !dataAccess; // data side always wins.
    assign rawAddr    = dataAccess ? dataAddr : pc;

    always_comb begin
        memBus.addr   = 32'(rawAddr[ADDR_WIDTH-1:0]);
        memBus.wrData = dataWr;
        memBus.read   = dataRead || fetchGrant; // fetch is a read.
        memBus.write  = dataWrite;
    end

endmodule

//--- logic/processor.sv
`timescale 1ns/1ns

module processor #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic            Clock,
    input  logic            nReset,
    output cpuPkg::memReq_t memBus,
    input  logic [31:0]     memRdata,
    input  logic [4:0]      regAddr,
    output logic [31:0]     regData
);

    import cpuPkg::*;

    typedef struct packed {
        logic [31:0] pc;
        instr_t      instr;
    } ifdReg_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] pc;
        logic [31:0] rsData;
        logic [31:0] rtData;
        logic [31:0] imm;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
    } dexReg_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] aluResult;
        logic [31:0] storeData;
        logic [4:0]  rd;
    } exmReg_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] result;
        logic [4:0]  rd;
    } mwReg_t;

    ifdReg_t     ifd;
    dexReg_t     dex;
    exmReg_t     exm;
    mwReg_t      mw;
    logic [31:0] fetchPc;
    instr_t      fetchInstr;
    logic        fetchValid;
    logic        fetchGrant;
    ctrl_t       decCtrl;
    logic [31:0] decRsData;
    logic [31:0] decRtData;
    logic [31:0] decImm;
    logic [4:0]  decRs;
    logic [4:0]  decRt;
    logic [4:0]  decRd;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] exAluResult;
    logic        exRegWrite;
    ctrl_t       exCtrl;
    logic        branchTaken;
    logic [31:0] branchTarget;
    fwdSel_t     fwdA;
    fwdSel_t     fwdB;
    logic        stall;
    logic        flush;
    logic [31:0] wbData;
    memReq_t     busReq;

    function automatic logic [31:0] forward(
        input fwdSel_t     sel,
        input logic [31:0] regVal,
        input logic [31:0] memVal,
        input logic [31:0] wbVal
    );
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    // ==============================
    // fetch and decode
    // ==============================

    fetchStage #(.ADDR_WIDTH(ADDR_WIDTH)) fetch_i (
        .Clock       (Clock),
        .nReset      (nReset),
        .hold        (stall),
        .fetchGrant  (fetchGrant),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget),
        .fetchData   (memRdata),
        .pc          (fetchPc),
        .instr       (fetchInstr),
        .instrValid  (fetchValid)
    );

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            ifd <= '0;
        end else if (flush) begin
            ifd <= '0;
        end else if (!stall) begin
            ifd.pc    <= fetchPc;
            ifd.instr <= fetchValid ? fetchInstr : '0; // word 0 decodes as nop.
        end
    end

    decodeStage decode_i (
        .Clock  (Clock),
        .nReset (nReset),
        .instr  (ifd.instr),
        .wrEn   (mw.ctrl.regWrite),
        .wrAddr (mw.rd),
        .wrData (wbData),
        .regAddr(regAddr),
        .regData(regData),
        .ctrl   (decCtrl),
        .rsData (decRsData),
        .rtData (decRtData),
        .imm    (decImm),
        .rs     (decRs),
        .rt     (decRt),
        .rd     (decRd)
    );

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            dex <= '0;
        end else begin
            dex.ctrl   <= (flush || stall) ? ctrl_t'('0) : decCtrl;
            dex.pc     <= ifd.pc;
            dex.rsData <= decRsData;
            dex.rtData <= decRtData;
            dex.imm    <= decImm;
            dex.rs     <= decRs;
            dex.rt     <= decRt;
            dex.rd     <= decRd;
        end
    end

    // ==============================
    // execute, memory, writeback
    // ==============================

    assign opA = forward(fwdA, dex.rsData, exm.aluResult, wbData);
    assign opB = forward(fwdB, dex.rtData, exm.aluResult, wbData);

    executeStage execute_i (
        .ctrl        (dex.ctrl),
        .pc          (dex.pc),
        .opA         (opA),
        .opB         (opB),
        .imm         (dex.imm),
        .aluResult   (exAluResult),
        .regWriteOut (exRegWrite),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget)
    );

    always_comb begin
        exCtrl          = dex.ctrl;
        exCtrl.regWrite = exRegWrite; // movz/movn outcome.
    end

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            exm <= '0;
            mw  <= '0;
        end else begin
            exm.ctrl      <= exCtrl;
            exm.aluResult <= exAluResult;
            exm.storeData <= opB;
            exm.rd        <= dex.rd;
            mw.ctrl       <= exm.ctrl;
            mw.result     <= exm.ctrl.memToReg ? memRdata : exm.aluResult;
            mw.rd         <= exm.rd;
        end
    end

    assign wbData = mw.result;

    hazardUnit hazard_i (
        .exRegWrite (dex.ctrl.regWrite),
        .exMemRead  (dex.ctrl.memRead),
        .exRd       (dex.rd),
        .memRegWrite(exm.ctrl.regWrite),
        .memRd      (exm.rd),
        .wbRegWrite (mw.ctrl.regWrite),
        .wbRd       (mw.rd),
        .exRs       (dex.rs),
        .exRt       (dex.rt),
        .decRs      (decRs),
        .decRt      (decRt),
        .branchTaken(branchTaken),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .stall      (stall),
        .flush      (flush)
    );

    memArbiter #(.ADDR_WIDTH(ADDR_WIDTH)) arbiter_i (
        .pc        (fetchPc),
        .dataAddr  (exm.aluResult),
        .dataWr    (exm.storeData),
        .dataRead  (exm.ctrl.memRead),
        .dataWrite (exm.ctrl.memWrite),
        .memBus    (busReq),
        .fetchGrant(fetchGrant)
    );

    always_comb begin
        memBus      = busReq;
        memBus.read = busReq.read && nReset; // bus idle while in reset.
    end

endmodule
